// ==== verilog/mem_settings.svh ====
// --------------------
// global sizes for the multi-port test memory
// --------------------

`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// number of request/response port pairs
`define MEM_NUM_PORTS 4

// physical memory size in bytes
`define MEM_SIZE_BYTES 1024

// message field widths
`define MEM_ADDR_W 16
`define MEM_DATA_W 32

// log2(MEM_SIZE_BYTES/4)
`define MEM_WORD_IDX_W 8

`endif

// ==== verilog/mem_pkg.sv ====
// --------------------
// message types shared by the memory blocks
// --------------------

`default_nettype none

`include "mem_settings.svh"

package mem_pkg;

  // request and response type field
  typedef enum logic [2:0]
  {
    mem_read    = 3'd0,
    mem_write   = 3'd1,
    mem_amo_add = 3'd2,
    mem_amo_and = 3'd3,
    mem_amo_or  = 3'd4,
    mem_amo_xch = 3'd5
  } mem_type_e;

  // length code, zero means a full word
  typedef logic [1:0] mem_len_t;

  localparam mem_len_t mem_len_word = 2'd0;
  localparam mem_len_t mem_len_byte = 2'd1;
  localparam mem_len_t mem_len_half = 2'd2;

  typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [`MEM_DATA_W-1:0] mem_data_t;
  typedef logic [1:0]             mem_port_idx_t;
  typedef logic [3:0]             mem_be_t;

endpackage

`default_nettype wire

// ==== verilog/mem_access_if.sv ====
// --------------------
// granted access from the port control to the datapath
// --------------------

`timescale 1ns/100ps
`default_nettype none

`include "mem_settings.svh"

interface mem_access_if;

  // one access per clock, valid while acc_en is high
  logic                   acc_en;
  logic [2:0]             acc_type;
  logic [`MEM_ADDR_W-1:0] acc_addr;
  logic [1:0]             acc_len;
  logic [`MEM_DATA_W-1:0] acc_data;

  // response payload for the granted port
  logic [`MEM_DATA_W-1:0] rd_data;

  modport ctrl (output acc_en, acc_type, acc_addr, acc_len, acc_data,
                input  rd_data);

  modport dp (input  acc_en, acc_type, acc_addr, acc_len, acc_data,
              output rd_data);

endinterface

`default_nettype wire

// ==== verilog/mem_port_ctrl.sv ====
// --------------------
// round-robin arbiter and per-port response slots
// --------------------

`timescale 1ns/100ps
`default_nettype none

`include "mem_settings.svh"

module mem_port_ctrl
  import mem_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,

  input  logic [`MEM_NUM_PORTS-1:0] memreq_val,
  output logic [`MEM_NUM_PORTS-1:0] memreq_rdy,
  input  mem_type_e                 memreq_type [`MEM_NUM_PORTS],
  input  mem_addr_t                 memreq_addr [`MEM_NUM_PORTS],
  input  mem_len_t                  memreq_len  [`MEM_NUM_PORTS],
  input  mem_data_t                 memreq_data [`MEM_NUM_PORTS],

  output logic [`MEM_NUM_PORTS-1:0] memresp_val,
  input  logic [`MEM_NUM_PORTS-1:0] memresp_rdy,
  output mem_type_e                 memresp_type [`MEM_NUM_PORTS],
  output mem_len_t                  memresp_len  [`MEM_NUM_PORTS],
  output mem_data_t                 memresp_data [`MEM_NUM_PORTS],

  mem_access_if.ctrl                acc
);

  mem_port_idx_t             ptr;
  mem_port_idx_t             gnt_idx;
  logic                      gnt_val;
  logic [`MEM_NUM_PORTS-1:0] eligible;

  // --------------------
  // arbitration

  // a full slot can take a new response only while it drains
  assign eligible = memreq_val & (~memresp_val | memresp_rdy);

  always_comb
  begin : arb
    int unsigned cand;
    gnt_val = 1'b0;
    gnt_idx = ptr;
    for (int i = 0; i < `MEM_NUM_PORTS; i++)
    begin
      cand = (int'(ptr) + i) % `MEM_NUM_PORTS;
      if (eligible[cand] && !gnt_val)
      begin
        gnt_val = 1'b1;
        gnt_idx = mem_port_idx_t'(cand);
      end
    end
  end

  always_comb
  begin
    for (int p = 0; p < `MEM_NUM_PORTS; p++)
      memreq_rdy[p] = gnt_val && (gnt_idx == mem_port_idx_t'(p));
  end

  // next search starts just past the winner
  always_ff @(posedge clk)
  begin
    if (reset)
      ptr <= '0;
    else if (gnt_val)
      ptr <= (gnt_idx == `MEM_NUM_PORTS-1) ? '0 : mem_port_idx_t'(gnt_idx + 1'b1);
  end

  // --------------------
  // granted access

  assign acc.acc_en   = gnt_val;
  assign acc.acc_type = memreq_type[gnt_idx];
  assign acc.acc_addr = memreq_addr[gnt_idx];
  assign acc.acc_len  = memreq_len[gnt_idx];
  assign acc.acc_data = memreq_data[gnt_idx];

  // --------------------
  // response slots

  always_ff @(posedge clk)
  begin
    for (int p = 0; p < `MEM_NUM_PORTS; p++)
    begin
      if (reset)
        memresp_val[p] <= 1'b0;
      else if (memreq_rdy[p])
        memresp_val[p] <= 1'b1;
      else if (memresp_rdy[p])
        memresp_val[p] <= 1'b0;
    end
  end

  // payload is captured with the request transfer
  always_ff @(posedge clk)
  begin
    for (int p = 0; p < `MEM_NUM_PORTS; p++)
    begin
      if (memreq_rdy[p])
      begin
        memresp_type[p] <= memreq_type[p];
        memresp_len[p]  <= memreq_len[p];
        memresp_data[p] <= acc.rd_data;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mem_lane_align.sv ====
// --------------------
// byte lane steering for writes and read data extraction
// --------------------

`timescale 1ns/100ps
`default_nettype none

`include "mem_settings.svh"

module mem_lane_align
  import mem_pkg::*;
(
  mem_access_if.dp                   acc,
  input  mem_data_t                  old_word,
  input  mem_data_t                  alu_word,
  output mem_data_t                  wr_word,
  output mem_be_t                    wr_be,
  output logic                       wr_en,
  output logic [`MEM_WORD_IDX_W-1:0] word_idx
);

  logic [1:0] off;
  logic       is_amo;
  mem_data_t  shifted;

  // upper address bits wrap at the memory size
  assign word_idx = acc.acc_addr[`MEM_WORD_IDX_W+1:2];
  assign off      = acc.acc_addr[1:0];
  assign is_amo   = acc.acc_type inside {mem_amo_add, mem_amo_and, mem_amo_or, mem_amo_xch};
  assign wr_en    = acc.acc_en && (acc.acc_type != mem_read);
  assign shifted  = old_word >> {off, 3'b000};

  // write lanes, subword data copied onto every lane
  always_comb
  begin
    wr_word = acc.acc_data;
    wr_be   = 4'b1111;
    if (is_amo)
      wr_word = alu_word;
    else if (acc.acc_len == mem_len_byte)
    begin
      wr_word = {4{acc.acc_data[7:0]}};
      wr_be   = 4'b0001 << off;
    end
    else if (acc.acc_len == mem_len_half)
    begin
      wr_word = {2{acc.acc_data[15:0]}};
      wr_be   = 4'b0011 << {off[1], 1'b0};
    end
  end

  // response data, zero extended for subword reads
  always_comb
  begin
    acc.rd_data = old_word;
    if (acc.acc_type == mem_write)
      acc.rd_data = '0;
    else if (acc.acc_type == mem_read && acc.acc_len == mem_len_byte)
      acc.rd_data = mem_data_t'(shifted[7:0]);
    else if (acc.acc_type == mem_read && acc.acc_len == mem_len_half)
      acc.rd_data = mem_data_t'(shifted[15:0]);
  end

endmodule

`default_nettype wire

// ==== verilog/mem_amo_alu.sv ====
// --------------------
// new word for atomic operations
// --------------------

`timescale 1ns/100ps
`default_nettype none

`include "mem_settings.svh"

module mem_amo_alu
  import mem_pkg::*;
(
  mem_access_if.dp  acc,
  input  mem_data_t old_word,
  output mem_data_t alu_word
);

  mem_data_t sum_word;
  mem_data_t and_word;
  mem_data_t or_word;

  assign sum_word = old_word + acc.acc_data;
  assign and_word = old_word & acc.acc_data;
  assign or_word  = old_word | acc.acc_data;

  // exchange and plain writes both store the request data
  always_comb
  begin
    case (acc.acc_type)
      mem_amo_add:
        alu_word = sum_word;
      mem_amo_and:
        alu_word = and_word;
      mem_amo_or:
        alu_word = or_word;
      default:
        alu_word = acc.acc_data;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/mem_word_array.sv ====
// --------------------
// word storage, async read, byte enable write
// --------------------

`timescale 1ns/100ps
`default_nettype none

`include "mem_settings.svh"

module mem_word_array
  import mem_pkg::*;
(
  input  logic                       clk,
  input  logic [`MEM_WORD_IDX_W-1:0] word_idx,
  input  mem_data_t                  wr_word,
  input  mem_be_t                    wr_be,
  input  logic                       wr_en,
  output mem_data_t                  old_word
);

  localparam int c_num_words = `MEM_SIZE_BYTES / 4;

  mem_data_t mem [c_num_words];

  // read and modify happen in the same cycle
  assign old_word = mem[word_idx];

  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (wr_be[b])
          mem[word_idx][b*8 +: 8] <= wr_word[b*8 +: 8];
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mem_multiport.sv ====
// --------------------
// multi-port test memory, one shared word array
// --------------------

`timescale 1ns/100ps
`default_nettype none

`include "mem_settings.svh"

module mem_multiport
  import mem_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,

  input  logic [`MEM_NUM_PORTS-1:0] memreq_val,
  output logic [`MEM_NUM_PORTS-1:0] memreq_rdy,
  input  mem_type_e                 memreq_type [`MEM_NUM_PORTS],
  input  mem_addr_t                 memreq_addr [`MEM_NUM_PORTS],
  input  mem_len_t                  memreq_len  [`MEM_NUM_PORTS],
  input  mem_data_t                 memreq_data [`MEM_NUM_PORTS],

  output logic [`MEM_NUM_PORTS-1:0] memresp_val,
  input  logic [`MEM_NUM_PORTS-1:0] memresp_rdy,
  output mem_type_e                 memresp_type [`MEM_NUM_PORTS],
  output mem_len_t                  memresp_len  [`MEM_NUM_PORTS],
  output mem_data_t                 memresp_data [`MEM_NUM_PORTS]
);

  mem_access_if acc ();

  mem_data_t                  old_word;
  mem_data_t                  alu_word;
  mem_data_t                  wr_word;
  mem_be_t                    wr_be;
  logic                       wr_en;
  logic [`MEM_WORD_IDX_W-1:0] word_idx;

  // --------------------
  // port side

  mem_port_ctrl i_port_ctrl
  (
    .clk          (clk),
    .reset        (reset),
    .memreq_val   (memreq_val),
    .memreq_rdy   (memreq_rdy),
    .memreq_type  (memreq_type),
    .memreq_addr  (memreq_addr),
    .memreq_len   (memreq_len),
    .memreq_data  (memreq_data),
    .memresp_val  (memresp_val),
    .memresp_rdy  (memresp_rdy),
    .memresp_type (memresp_type),
    .memresp_len  (memresp_len),
    .memresp_data (memresp_data),
    .acc          (acc.ctrl)
  );

  // --------------------
  // datapath

  mem_lane_align i_lane_align
  (
    .acc      (acc.dp),
    .old_word (old_word),
    .alu_word (alu_word),
    .wr_word  (wr_word),
    .wr_be    (wr_be),
    .wr_en    (wr_en),
    .word_idx (word_idx)
  );

  mem_amo_alu i_amo_alu
  (
    .acc      (acc.dp),
    .old_word (old_word),
    .alu_word (alu_word)
  );

  mem_word_array i_word_array
  (
    .clk      (clk),
    .word_idx (word_idx),
    .wr_word  (wr_word),
    .wr_be    (wr_be),
    .wr_en    (wr_en),
    .old_word (old_word)
  );

endmodule

`default_nettype wire

// ==== test/mem_multiport_checker.sv ====
// --------------------
// handshake and timing properties of the multi-port memory
// --------------------

`timescale 1ns/100ps
`default_nettype none

`include "mem_settings.svh"

module mem_multiport_checker
  import mem_pkg::*;
(
  input logic                      clk,
  input logic                      reset,
  input logic [`MEM_NUM_PORTS-1:0] memreq_val,
  input logic [`MEM_NUM_PORTS-1:0] memreq_rdy,
  input logic [`MEM_NUM_PORTS-1:0] memresp_val,
  input logic [`MEM_NUM_PORTS-1:0] memresp_rdy,
  input mem_type_e                 memresp_type [`MEM_NUM_PORTS],
  input mem_len_t                  memresp_len  [`MEM_NUM_PORTS],
  input mem_data_t                 memresp_data [`MEM_NUM_PORTS]
);

  int unsigned fail_count = 0;

  // slots come out of reset empty
  reset_empty: assert property (@(posedge clk) reset |=> memresp_val == '0)
  else
  begin
    $error("response valid set after reset");
    fail_count++;
  end

  // --------------------
  // arbitration

  one_grant: assert property (@(posedge clk) disable iff (reset) $onehot0(memreq_rdy))
  else
  begin
    $error("more than one memreq_rdy high");
    fail_count++;
  end

  grant_needs_val: assert property (@(posedge clk) disable iff (reset)
    (memreq_rdy & ~memreq_val) == '0)
  else
  begin
    $error("memreq_rdy high on a port without memreq_val");
    fail_count++;
  end

  // --------------------
  // per port latency and back-pressure

  for (genvar p = 0; p < `MEM_NUM_PORTS; p++)
  begin : g_port
    resp_latency: assert property (@(posedge clk) disable iff (reset)
      memreq_val[p] && memreq_rdy[p] |=> memresp_val[p])
    else
    begin
      $error("no response one cycle after a request on port %0d", p);
      fail_count++;
    end

    // held response keeps its message
    resp_hold: assert property (@(posedge clk) disable iff (reset)
      memresp_val[p] && !memresp_rdy[p] |=> memresp_val[p] && $stable(memresp_type[p])
        && $stable(memresp_len[p]) && $stable(memresp_data[p]))
    else
    begin
      $error("held response changed on port %0d", p);
      fail_count++;
    end

    full_blocks_req: assert property (@(posedge clk) disable iff (reset)
      memresp_val[p] && !memresp_rdy[p] |-> !memreq_rdy[p])
    else
    begin
      $error("request accepted on port %0d while its response is held", p);
      fail_count++;
    end
  end

endmodule

bind mem_multiport mem_multiport_checker i_checker
(
  .clk          (clk),
  .reset        (reset),
  .memreq_val   (memreq_val),
  .memreq_rdy   (memreq_rdy),
  .memresp_val  (memresp_val),
  .memresp_rdy  (memresp_rdy),
  .memresp_type (memresp_type),
  .memresp_len  (memresp_len),
  .memresp_data (memresp_data)
);

`default_nettype wire

// ==== test/tb_mem_multiport.sv ====
// --------------------
// testbench for the multi-port memory with a byte model
// --------------------

`timescale 1ns/100ps
`default_nettype none

`include "mem_settings.svh"

module tb_mem_multiport
  import mem_pkg::*;
();

  localparam int c_ports       = `MEM_NUM_PORTS;
  localparam int c_bytes       = `MEM_SIZE_BYTES;
  localparam int c_window      = 32;
  localparam int c_stride      = c_bytes / 4 / c_window;
  localparam int c_held_port   = c_ports / 2;
  localparam int c_wait_limit  = 200;
  localparam int c_phase_limit = 4000;
  localparam int c_run_limit   = 40000;

  typedef struct packed
  {
    mem_type_e t;
    mem_len_t  l;
    mem_data_t d;
  } resp_t;

  logic               clk = 1'b0;
  logic               reset;
  logic [c_ports-1:0] memreq_val;
  logic [c_ports-1:0] memreq_rdy;
  mem_type_e          memreq_type [c_ports];
  mem_addr_t          memreq_addr [c_ports];
  mem_len_t           memreq_len  [c_ports];
  mem_data_t          memreq_data [c_ports];
  logic [c_ports-1:0] memresp_val;
  logic [c_ports-1:0] memresp_rdy;
  mem_type_e          memresp_type [c_ports];
  mem_len_t           memresp_len  [c_ports];
  mem_data_t          memresp_data [c_ports];

  logic [7:0]         model [c_bytes];
  resp_t              exp_q [c_ports][$];
  int unsigned        req_count [c_ports];
  int unsigned        base_count [c_ports];
  int unsigned        tb_errors = 0;
  int unsigned        done_ports;
  int                 last_gnt = c_ports - 1;
  logic               rr_check = 1'b0;
  logic               all_ready = 1'b1;
  logic [c_ports-1:0] hold_mask = '0;
  logic               timeout_hit = 1'b0;

  always #4 clk = ~clk;

  mem_multiport i_mem_multiport
  (
    .clk          (clk),
    .reset        (reset),
    .memreq_val   (memreq_val),
    .memreq_rdy   (memreq_rdy),
    .memreq_type  (memreq_type),
    .memreq_addr  (memreq_addr),
    .memreq_len   (memreq_len),
    .memreq_data  (memreq_data),
    .memresp_val  (memresp_val),
    .memresp_rdy  (memresp_rdy),
    .memresp_type (memresp_type),
    .memresp_len  (memresp_len),
    .memresp_data (memresp_data)
  );

  // --------------------
  // checking helpers

  task automatic compare_field(input string name, input mem_data_t expv, input mem_data_t actv);
    assert (actv == expv)
    else
    begin
      tb_errors++;
      $display("ERROR %0t %s expected %h actual %h", $time, name, expv, actv);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s at %0t", what, $time);
    tb_errors++;
    timeout_hit = 1'b1;
  endtask

  task automatic finish_run();
    $display("errors: testbench %0d, checker %0d", tb_errors,
             i_mem_multiport.i_checker.fail_count);
    if (tb_errors == 0 && i_mem_multiport.i_checker.fail_count == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  endtask

  // expected response and model update at a request transfer
  task automatic apply_request(input int p);
    int unsigned a;
    int unsigned wa;
    int unsigned n;
    mem_data_t   old;
    mem_data_t   nw;
    resp_t       r;
    a   = int'(memreq_addr[p]) % c_bytes;
    wa  = a - a % 4;
    old = {model[wa+3], model[wa+2], model[wa+1], model[wa]};
    nw  = memreq_data[p];
    n   = (memreq_len[p] == mem_len_byte) ? 1 : (memreq_len[p] == mem_len_half) ? 2 : 4;
    r.t = memreq_type[p];
    r.l = memreq_len[p];
    r.d = old;
    case (memreq_type[p])
      mem_read:
      begin
        if (n == 1)
          r.d = mem_data_t'(model[a]);
        else if (n == 2)
          r.d = mem_data_t'({model[a+1], model[a]});
      end
      mem_write:
      begin
        r.d = '0;
        for (int i = 0; i < n; i++)
          model[a+i] = nw[8*i +: 8];
      end
      default:
      begin
        // atomics return the old word and store the combined one
        if (memreq_type[p] == mem_amo_add)
          nw = old + memreq_data[p];
        else if (memreq_type[p] == mem_amo_and)
          nw = old & memreq_data[p];
        else if (memreq_type[p] == mem_amo_or)
          nw = old | memreq_data[p];
        for (int i = 0; i < 4; i++)
          model[wa+i] = nw[8*i +: 8];
      end
    endcase
    exp_q[p].push_back(r);
    req_count[p]++;
    if (rr_check)
      compare_field("granted port", mem_data_t'((last_gnt + 1) % c_ports), mem_data_t'(p));
    last_gnt = p;
  endtask

  task automatic check_response(input int p);
    resp_t e;
    assert (exp_q[p].size() != 0)
    else
    begin
      tb_errors++;
      $display("port %0d gave a response with no request outstanding at %0t", p, $time);
    end
    if (exp_q[p].size() != 0)
    begin
      e = exp_q[p].pop_front();
      compare_field($sformatf("memresp_type[%0d]", p), e.t, memresp_type[p]);
      compare_field($sformatf("memresp_len[%0d]", p), e.l, memresp_len[p]);
      compare_field($sformatf("memresp_data[%0d]", p), e.d, memresp_data[p]);
    end
  endtask

  // transfers observed half a cycle before their edge
  always @(negedge clk)
  begin
    if (!reset)
    begin
      if (rr_check)
      begin
        assert (memreq_rdy != '0)
        else
        begin
          tb_errors++;
          $display("no grant while every port requests at %0t", $time);
        end
      end
      for (int p = 0; p < c_ports; p++)
      begin
        if (memresp_val[p] && memresp_rdy[p])
          check_response(p);
        if (memreq_val[p] && memreq_rdy[p])
          apply_request(p);
      end
    end
  end

  // response sinks
  always @(posedge clk)
  begin
    #1;
    for (int p = 0; p < c_ports; p++)
      memresp_rdy[p] = (all_ready || $urandom_range(3, 0) != 0) && !hold_mask[p];
  end

  // --------------------
  // stimulus

  function automatic mem_addr_t make_addr(input int unsigned k, input int unsigned off);
    mem_addr_t   a;
    int unsigned w;
    // random upper bits exercise the address wrap
    a = mem_addr_t'($urandom);
    w = k * c_stride + 3;
    a[`MEM_WORD_IDX_W+1:2] = w[`MEM_WORD_IDX_W-1:0];
    a[1:0] = off[1:0];
    return a;
  endfunction

  // called just after a rising edge and returns just after the transfer edge
  task automatic send_request(input int p, input mem_type_e t, input mem_addr_t a,
                              input mem_len_t l, input mem_data_t d);
    int unsigned n;
    memreq_type[p] = t;
    memreq_addr[p] = a;
    memreq_len[p]  = l;
    memreq_data[p] = d;
    memreq_val[p]  = 1'b1;
    n = 0;
    @(negedge clk);
    while (!memreq_rdy[p] && n < c_wait_limit)
    begin
      @(negedge clk);
      n++;
    end
    if (!memreq_rdy[p])
      report_timeout($sformatf("memreq_rdy[%0d]", p));
    @(posedge clk);
    #1;
    memreq_val[p] = 1'b0;
  endtask

  task automatic random_op(input int p);
    mem_type_e   t;
    mem_len_t    l;
    int unsigned off;
    int unsigned gap;
    t   = mem_type_e'($urandom_range(5, 0));
    l   = mem_len_word;
    off = 0;
    if (t == mem_read || t == mem_write)
    begin
      l = mem_len_t'($urandom_range(2, 0));
      if (l == mem_len_byte)
        off = $urandom_range(3, 0);
      else if (l == mem_len_half)
        off = 2 * $urandom_range(1, 0);
    end
    send_request(p, t, make_addr($urandom_range(c_window - 1, 0), off), l, $urandom);
    gap = $urandom_range(2, 0);
    repeat (gap)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic directed_ops(input int p);
    mem_addr_t a;
    a = make_addr(p, 0);
    send_request(p, mem_write, a, mem_len_word, $urandom);
    send_request(p, mem_read, a, mem_len_word, '0);
    send_request(p, mem_write, a | mem_addr_t'(1), mem_len_byte, $urandom);
    send_request(p, mem_write, a | mem_addr_t'(2), mem_len_half, $urandom);
    send_request(p, mem_read, a | mem_addr_t'(3), mem_len_byte, '0);
    send_request(p, mem_read, a | mem_addr_t'(2), mem_len_half, '0);
    send_request(p, mem_read, a, mem_len_word, '0);
    for (int t = 2; t <= 5; t++)
    begin
      send_request(p, mem_type_e'(t), a, mem_len_word, $urandom);
      send_request(p, mem_read, a, mem_len_word, '0);
    end
  endtask

  task automatic port_traffic(input int p, input bit back_to_back, input int count);
    for (int i = 0; i < count; i++)
    begin
      if (back_to_back)
        send_request(p, mem_read, make_addr((i * c_ports + p) % c_window, 0), mem_len_word, '0);
      else
        random_op(p);
    end
  endtask

  task automatic run_ports(input bit back_to_back, input int count);
    int unsigned n;
    done_ports = 0;
    for (int p = 0; p < c_ports; p++)
    begin
      fork
        automatic int q = p;
        begin
          port_traffic(q, back_to_back, count);
          done_ports++;
        end
      join_none
    end
    n = 0;
    while (done_ports < c_ports && n < c_phase_limit)
    begin
      @(posedge clk);
      n++;
    end
    if (done_ports < c_ports)
      report_timeout("all ports to finish their requests");
    #1;
  endtask

  task automatic drain_responses();
    int unsigned n;
    n = 0;
    @(negedge clk);
    while (memresp_val != '0 && n < c_wait_limit)
    begin
      @(negedge clk);
      n++;
    end
    if (memresp_val != '0)
      report_timeout("responses to drain");
    for (int p = 0; p < c_ports; p++)
      compare_field($sformatf("outstanding responses on port %0d", p), '0, exp_q[p].size());
  endtask

  initial
  begin : watchdog
    int unsigned n;
    n = 0;
    while (!timeout_hit && n < c_run_limit)
    begin
      @(posedge clk);
      n++;
    end
    if (!timeout_hit)
      $display("run exceeded %0d cycles", c_run_limit);
    tb_errors++;
    finish_run();
  end

  initial
  begin : main
    void'($urandom(32'hf3355e96));
    reset       = 1'b1;
    memreq_val  = '0;
    memresp_rdy = '0;
    for (int p = 0; p < c_ports; p++)
    begin
      memreq_type[p] = mem_read;
      memreq_addr[p] = '0;
      memreq_len[p]  = mem_len_word;
      memreq_data[p] = '0;
      req_count[p]   = 0;
    end
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    // memory is not cleared by reset so the test window is written first
    for (int k = 0; k < c_window; k++)
      send_request(k % c_ports, mem_write, make_addr(k, 0), mem_len_word, $urandom);
    for (int p = 0; p < c_ports; p++)
      directed_ops(p);

    // grants rotate while every port requests
    fork
      run_ports(1'b1, 12);
      begin
        repeat (3) @(posedge clk);
        rr_check = 1'b1;
        repeat (c_ports * 8) @(posedge clk);
        rr_check = 1'b0;
      end
    join

    // one port held full while the others keep going
    hold_mask = c_ports'(1) << c_held_port;
    @(posedge clk);
    #1;
    base_count = req_count;
    fork
      run_ports(1'b0, 6);
      begin
        repeat (50) @(posedge clk);
        for (int p = 0; p < c_ports; p++)
          compare_field($sformatf("transfers on port %0d", p),
                        base_count[p] + ((p == c_held_port) ? 1 : 6), req_count[p]);
        #1;
        hold_mask = '0;
      end
    join

    // random traffic with random response back-pressure
    all_ready = 1'b0;
    run_ports(1'b0, 40);
    all_ready = 1'b1;
    drain_responses();
    finish_run();
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+verilog
verilog/mem_pkg.sv
verilog/mem_access_if.sv
verilog/mem_port_ctrl.sv
verilog/mem_lane_align.sv
verilog/mem_amo_alu.sv
verilog/mem_word_array.sv
verilog/mem_multiport.sv
test/mem_multiport_checker.sv
test/tb_mem_multiport.sv

// ==== Makefile ====
# Verilator build and run for the multi-port memory testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_multiport
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "TB PASSED" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
